// File: filelist.f
+incdir+source
source/lsu_pkg.sv
source/lsu_stage_reg.sv
source/lsu_req_format.sv
source/lsu_wb_master.sv
source/lsu_load_align.sv
source/lsu_top.sv
tests/tb_wb_memory.sv
tests/tb_lsu_top.sv

// File: run.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_lsu_top -o sim_lsu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_lsu > sim.log 2>&1
status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0

// File: source/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Data word width
`define LSU_XLEN 32

// Byte address width
`define LSU_AW 32

// Register index width
`define LSU_RW 5

`endif

// File: source/lsu_load_align.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_load_align (
    input  logic                 clk,
    input  logic                 arst_n,

    input  logic                 cap_valid,
    output logic                 cap_ready,
    input  lsu_pkg::lsu_cmd_t    cap_cmd,
    input  logic [`LSU_XLEN-1:0] cap_dat,

    output logic                 wb_valid,
    input  logic                 wb_ready,
    output lsu_pkg::lsu_wb_t     wb
);

    localparam logic [`LSU_XLEN-1:0] ALL_ONES = '1;

    logic [4:0]           shl_amt;
    logic [4:0]           shr_amt;
    logic [`LSU_XLEN-1:0] dat_shr;
    logic [7:0]           byte_v;
    logic [15:0]          half_v;
    lsu_pkg::lsu_wb_t     result;

    // Lane 0 sits at the top of the word
    assign shl_amt = {cap_cmd.lane, 3'b000};
    assign shr_amt = {~cap_cmd.lane, 3'b000};  // 8 * (3 - lane)
    assign dat_shr = cap_dat >> shr_amt;
    assign byte_v  = dat_shr[7:0];
    assign half_v  = cap_cmd.lane[1] ? cap_dat[15:0] : cap_dat[31:16];

    always_comb begin
        result.rt = cap_cmd.rt;
        case (cap_cmd.op)
            lsu_pkg::OP_LB: begin
                result.data = {{(`LSU_XLEN-8){byte_v[7]}}, byte_v};
            end
            lsu_pkg::OP_LBU: begin
                result.data = {{(`LSU_XLEN-8){1'b0}}, byte_v};
            end
            lsu_pkg::OP_LH: begin
                result.data = {{(`LSU_XLEN-16){half_v[15]}}, half_v};
            end
            lsu_pkg::OP_LHU: begin
                result.data = {{(`LSU_XLEN-16){1'b0}}, half_v};
            end
            lsu_pkg::OP_LWL: begin
                // Memory fills from the top, old low bytes survive
                result.data = (cap_dat << shl_amt)
                            | (cap_cmd.rt_data & ~(ALL_ONES << shl_amt));
            end
            lsu_pkg::OP_LWR: begin
                result.data = dat_shr
                            | (cap_cmd.rt_data & ~(ALL_ONES >> shr_amt));  // Keep high bytes
            end
            lsu_pkg::OP_LUI: begin
                result.data = {cap_cmd.imm, 16'h0000};
            end
            default: begin
                result.data = cap_dat;  // lw
            end
        endcase
    end

    // Result register toward the core
    lsu_stage_reg #(
        .payload_t (lsu_pkg::lsu_wb_t)
    ) i_wb_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (cap_valid),
        .in_ready  (cap_ready),
        .in_data   (result),
        .out_valid (wb_valid),
        .out_ready (wb_ready),
        .out_data  (wb)
    );

    a_no_store_capture: assert property (
        @(posedge clk) disable iff (!arst_n)
        cap_valid |-> !cap_cmd.we
    ) else $error("store reached the load aligner");

endmodule

// File: source/lsu_pkg.sv
`include "lsu_cfg.svh"

package lsu_pkg;

    typedef enum logic [3:0] {
        OP_LB,   // Load byte, sign extended
        OP_LBU,  // Load byte, zero extended
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_LWL,  // Merge from the left
        OP_LWR,  // Merge from the right
        OP_LUI,  // No bus cycle
        OP_SB,
        OP_SH,
        OP_SW
    } lsu_op_e;

    typedef struct packed {
        lsu_op_e                op;
        logic [`LSU_XLEN-1:0]   base;
        logic [15:0]            offset;
        logic [`LSU_XLEN-1:0]   rt_data;  // Old target value or store source
        logic [`LSU_RW-1:0]     rt;
    } lsu_req_t;

    typedef struct packed {
        lsu_op_e                op;
        logic [`LSU_AW-1:0]     adr;      // Word aligned
        logic [1:0]             lane;     // Byte offset in word
        logic                   we;
        logic [`LSU_XLEN/8-1:0] sel;
        logic [`LSU_XLEN-1:0]   wdat;
        logic [`LSU_XLEN-1:0]   rt_data;
        logic [`LSU_RW-1:0]     rt;
        logic [15:0]            imm;
    } lsu_cmd_t;

    typedef struct packed {
        logic [`LSU_RW-1:0]     rt;
        logic [`LSU_XLEN-1:0]   data;
    } lsu_wb_t;

    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`LSU_XLEN/8-1:0] sel;
        logic [`LSU_AW-1:0]     adr;
        logic [`LSU_XLEN-1:0]   dat;
    } lsu_wbm_o_t;

    typedef struct packed {
        logic                   ack;
        logic [`LSU_XLEN-1:0]   dat;
    } lsu_wbm_i_t;

endpackage

// File: source/lsu_req_format.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_req_format (
    input  lsu_pkg::lsu_req_t req,
    output lsu_pkg::lsu_cmd_t cmd
);

    logic [`LSU_XLEN-1:0] offset_sx;
    logic [`LSU_XLEN-1:0] eff_addr;
    logic [1:0]           lane;

    assign offset_sx = {{(`LSU_XLEN-16){req.offset[15]}}, req.offset};
    assign eff_addr  = req.base + offset_sx;
    assign lane      = eff_addr[1:0];

    always_comb begin
        cmd         = '0;
        cmd.op      = req.op;
        cmd.adr     = {eff_addr[`LSU_AW-1:2], 2'b00};  // Bus sees whole words only
        cmd.lane    = lane;
        cmd.rt_data = req.rt_data;
        cmd.rt      = req.rt;
        cmd.imm     = req.offset;
        cmd.we      = 1'b0;
        cmd.sel     = '0;
        cmd.wdat    = '0;

        // Big endian lanes, offset 0 is sel[3] and data[31:24]
        case (req.op)
            lsu_pkg::OP_LB,
            lsu_pkg::OP_LBU: begin
                cmd.sel = 4'b1000 >> lane;
            end
            lsu_pkg::OP_LH,
            lsu_pkg::OP_LHU: begin
                cmd.sel = lane[1] ? 4'b0011 : 4'b1100;
            end
            lsu_pkg::OP_LW: begin
                cmd.sel = 4'b1111;
            end
            lsu_pkg::OP_LWL: begin
                cmd.sel = 4'b1111 >> lane;  // Offset up to lane 3
            end
            lsu_pkg::OP_LWR: begin
                cmd.sel = ~(4'b0111 >> lane);  // Lane 0 up to offset
            end
            lsu_pkg::OP_SB: begin
                cmd.we   = 1'b1;
                cmd.sel  = 4'b1000 >> lane;
                cmd.wdat = {4{req.rt_data[7:0]}};  // Byte on every lane
            end
            lsu_pkg::OP_SH: begin
                cmd.we   = 1'b1;
                cmd.sel  = lane[1] ? 4'b0011 : 4'b1100;
                cmd.wdat = {2{req.rt_data[15:0]}};
            end
            lsu_pkg::OP_SW: begin
                cmd.we   = 1'b1;
                cmd.sel  = 4'b1111;
                cmd.wdat = req.rt_data;
            end
            default: begin
                cmd.sel = '0;  // lui never reaches the bus
            end
        endcase
    end

endmodule

// File: source/lsu_stage_reg.sv
`timescale 1ns/1ps

module lsu_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full;
    payload_t data_q;

    assign in_ready  = !full || out_ready;  // Empty or draining this cycle
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full <= 1'b0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;  // Refill even while draining
        end else if (out_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    // A stalled entry must neither vanish nor change under the consumer
    a_stall_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    ) else $error("stage register output changed while stalled");

endmodule

// File: source/lsu_top.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_top (
    input  logic                clk,
    input  logic                arst_n,

    input  logic                req_valid,
    output logic                req_ready,
    input  lsu_pkg::lsu_req_t   req,

    output logic                wb_valid,
    input  logic                wb_ready,
    output lsu_pkg::lsu_wb_t    wb,

    output lsu_pkg::lsu_wbm_o_t wbm_o,
    input  lsu_pkg::lsu_wbm_i_t wbm_i
);

    logic                 req_q_valid;
    logic                 req_q_ready;
    lsu_pkg::lsu_req_t    req_q;
    lsu_pkg::lsu_cmd_t    cmd;
    logic                 cap_valid;
    logic                 cap_ready;
    lsu_pkg::lsu_cmd_t    cap_cmd;
    logic [`LSU_XLEN-1:0] cap_dat;

    lsu_stage_reg #(
        .payload_t (lsu_pkg::lsu_req_t)
    ) i_req_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (req),
        .out_valid (req_q_valid),
        .out_ready (req_q_ready),
        .out_data  (req_q)
    );

    lsu_req_format i_req_format (
        .req (req_q),
        .cmd (cmd)
    );

    lsu_wb_master i_wb_master (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd_valid (req_q_valid),
        .cmd_ready (req_q_ready),  // Pops the request register
        .cmd       (cmd),
        .cap_ready (cap_ready),
        .cap_valid (cap_valid),
        .cap_cmd   (cap_cmd),
        .cap_dat   (cap_dat),
        .wbm_o     (wbm_o),
        .wbm_i     (wbm_i)
    );

    lsu_load_align i_load_align (
        .clk       (clk),
        .arst_n    (arst_n),
        .cap_valid (cap_valid),
        .cap_ready (cap_ready),
        .cap_cmd   (cap_cmd),
        .cap_dat   (cap_dat),
        .wb_valid  (wb_valid),
        .wb_ready  (wb_ready),
        .wb        (wb)
    );

endmodule

// File: source/lsu_wb_master.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_wb_master (
    input  logic                 clk,
    input  logic                 arst_n,

    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    input  lsu_pkg::lsu_cmd_t    cmd,

    input  logic                 cap_ready,
    output logic                 cap_valid,
    output lsu_pkg::lsu_cmd_t    cap_cmd,
    output logic [`LSU_XLEN-1:0] cap_dat,

    output lsu_pkg::lsu_wbm_o_t  wbm_o,
    input  lsu_pkg::lsu_wbm_i_t  wbm_i
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BUS,
        S_DONE
    } state_e;

    state_e               state;
    logic                 bus_q;
    logic                 we_q;
    lsu_pkg::lsu_cmd_t    cmd_q;
    logic [`LSU_XLEN-1:0] dat_q;
    logic                 take;
    logic                 bus_end;

    // Loads and lui wait for room in the aligner, stores go ahead
    assign cmd_ready = (state == S_IDLE) && (cmd.we || cap_ready);
    assign take      = cmd_valid && cmd_ready;
    assign bus_end   = (state == S_BUS) && wbm_i.ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
            bus_q <= 1'b0;
            we_q  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (take && cmd.op == lsu_pkg::OP_LUI) begin
                        state <= S_DONE;  // Skip the bus
                    end else if (take) begin
                        state <= S_BUS;
                        bus_q <= 1'b1;
                        we_q  <= cmd.we;
                    end
                end
                S_BUS: begin
                    if (wbm_i.ack) begin
                        bus_q <= 1'b0;
                        we_q  <= 1'b0;
                        state <= cmd_q.we ? S_IDLE : S_DONE;  // Stores end here
                    end
                end
                default: begin
                    if (cap_ready) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cmd_q <= cmd;
        end
        if (bus_end) begin
            dat_q <= wbm_i.dat;  // Sampled on the ack edge
        end
    end

    assign cap_valid = (state == S_DONE);
    assign cap_cmd   = cmd_q;
    assign cap_dat   = dat_q;

    always_comb begin
        wbm_o.cyc = bus_q;
        wbm_o.stb = bus_q;
        wbm_o.we  = we_q;
        wbm_o.sel = cmd_q.sel;
        wbm_o.adr = cmd_q.adr;
        wbm_o.dat = cmd_q.wdat;
    end

    a_bus_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        wbm_o.stb && !wbm_i.ack |=> wbm_o.stb && wbm_o.cyc
            && $stable({wbm_o.adr, wbm_o.sel, wbm_o.we, wbm_o.dat})
    ) else $error("bus cycle dropped or changed before ack");

    a_ack_in_cycle: assert property (
        @(posedge clk) disable iff (!arst_n)
        wbm_i.ack |-> wbm_o.stb && wbm_o.cyc
    ) else $error("ack outside a bus cycle");

    a_drop_after_ack: assert property (
        @(posedge clk) disable iff (!arst_n)
        wbm_o.stb && wbm_i.ack |=> !wbm_o.stb && !wbm_o.cyc
    ) else $error("bus cycle held past ack");

endmodule

// File: tests/tb_lsu_top.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module tb_lsu_top;

    localparam logic [31:0] SEED    = 32'h7f69_1157;
    localparam int          NUM_REQ = 200;
    localparam int          LIMIT   = NUM_REQ * 12 + 400;

    typedef struct packed {
        logic [`LSU_AW-1:0]     adr;
        logic                   we;
        logic [`LSU_XLEN/8-1:0] sel;
        logic [`LSU_XLEN-1:0]   dat;   // Store data on the bus
        logic [`LSU_XLEN-1:0]   word;  // Memory word after the access
    } bus_exp_t;

    logic                clk = 1'b0;
    logic                arst_n;
    logic                req_valid;
    logic                req_ready;
    lsu_pkg::lsu_req_t   req;
    logic                wb_valid;
    logic                wb_ready = 1'b0;
    lsu_pkg::lsu_wb_t    wb;
    lsu_pkg::lsu_wbm_o_t wbm_o;
    lsu_pkg::lsu_wbm_i_t wbm_i;
    logic                req_fire;

    logic [31:0]         req_rng   = SEED;
    logic [31:0]         ready_rng = ~SEED;
    int unsigned         cycles    = 0;
    logic [31:0]         shadow [0:63];
    bus_exp_t            bus_q [$];
    lsu_pkg::lsu_wb_t    wb_q [$];

    always #2 clk = ~clk;

    assign req_fire = req_valid && req_ready;

    lsu_top i_lsu_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .wb_valid  (wb_valid),
        .wb_ready  (wb_ready),
        .wb        (wb),
        .wbm_o     (wbm_o),
        .wbm_i     (wbm_i)
    );

    tb_wb_memory #(
        .SEED (SEED)
    ) i_mem (
        .clk    (clk),
        .arst_n (arst_n),
        .wbm_o  (wbm_o),
        .wbm_i  (wbm_i)
    );

    task automatic report_failure(input string msg);
        $display("FAILED %0t: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic lsu_pkg::lsu_op_e pick_op(input int n);
        case (n)
            0:       return lsu_pkg::OP_SB;
            1:       return lsu_pkg::OP_SH;
            2:       return lsu_pkg::OP_SW;
            3:       return lsu_pkg::OP_LB;
            4:       return lsu_pkg::OP_LBU;
            5:       return lsu_pkg::OP_LH;
            6:       return lsu_pkg::OP_LHU;
            7:       return lsu_pkg::OP_LW;
            8:       return lsu_pkg::OP_LWL;
            9:       return lsu_pkg::OP_LWR;
            default: return lsu_pkg::OP_LUI;
        endcase
    endfunction

    function automatic logic [7:0] byte_at(input int a);
        logic [7:0] b;
        b = 8'(a);
        return (b * 8'h3b) ^ 8'h96;
    endfunction

    function automatic logic [31:0] initial_word(input int w);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < 4; k++) begin
            v[31-8*k -: 8] = byte_at(w * 4 + k);  // Byte 0 at the top
        end
        return v;
    endfunction

    function automatic logic [3:0] lane_mask(input lsu_pkg::lsu_op_e op, input logic [1:0] lane);
        int         ln;
        logic       hit;
        logic [3:0] m;
        ln = int'(lane);
        m  = '0;
        for (int k = 0; k < 4; k++) begin
            case (op)
                lsu_pkg::OP_LB, lsu_pkg::OP_LBU, lsu_pkg::OP_SB: hit = (k == ln);
                lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH: hit = ((k / 2) == (ln / 2));
                lsu_pkg::OP_LWL: hit = (k >= ln);
                lsu_pkg::OP_LWR: hit = (k <= ln);
                default:         hit = 1'b1;
            endcase
            if (hit) begin
                m[3-k] = 1'b1;
            end
        end
        return m;
    endfunction

    function automatic logic [31:0] store_data(input lsu_pkg::lsu_op_e op, input logic [1:0] lane,
                                               input logic [31:0] src);
        logic [31:0] v;
        v = '0;
        case (op)
            lsu_pkg::OP_SB: v[31-8*int'(lane) -: 8] = src[7:0];  // Addressed lane only
            lsu_pkg::OP_SH: v = lane[1] ? {16'h0000, src[15:0]} : {src[15:0], 16'h0000};
            default:        v = src;
        endcase
        return v;
    endfunction

    function automatic logic [31:0] merge_store(input logic [31:0] word, input logic [3:0] sel,
                                                input logic [31:0] dat);
        logic [31:0] v;
        v = word;
        for (int k = 0; k < 4; k++) begin
            if (sel[3-k]) begin
                v[31-8*k -: 8] = dat[31-8*k -: 8];
            end
        end
        return v;
    endfunction

    function automatic logic [31:0] load_value(input lsu_pkg::lsu_op_e op, input logic [1:0] lane,
                                               input logic [31:0] word, input logic [31:0] old);
        int          ln;
        int          s;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] v;
        ln = int'(lane);
        s  = 3 - ln;
        b  = word[31-8*ln -: 8];
        h  = lane[1] ? word[15:0] : word[31:16];
        v  = word;
        case (op)
            lsu_pkg::OP_LB:  v = {{24{b[7]}}, b};
            lsu_pkg::OP_LBU: v = {24'h0, b};
            lsu_pkg::OP_LH:  v = {{16{h[15]}}, h};
            lsu_pkg::OP_LHU: v = {16'h0, h};
            lsu_pkg::OP_LWL: begin
                for (int k = 0; k < 4; k++) begin
                    if (k + ln <= 3) begin
                        v[31-8*k -: 8] = word[31-8*(k+ln) -: 8];
                    end else begin
                        v[31-8*k -: 8] = old[31-8*k -: 8];  // Old low bytes stay
                    end
                end
            end
            lsu_pkg::OP_LWR: begin
                for (int k = 0; k < 4; k++) begin
                    if (k >= s) begin
                        v[31-8*k -: 8] = word[31-8*(k-s) -: 8];
                    end else begin
                        v[31-8*k -: 8] = old[31-8*k -: 8];  // Old high bytes stay
                    end
                end
            end
            default: v = word;
        endcase
        return v;
    endfunction

    // Shadow memory moves in request order like the bus
    task automatic record_request(input lsu_pkg::lsu_req_t r);
        logic [31:0]      addr;
        logic [1:0]       lane;
        logic [5:0]       idx;
        bus_exp_t         e;
        lsu_pkg::lsu_wb_t w;
        addr   = r.base + {{16{r.offset[15]}}, r.offset};
        lane   = addr[1:0];
        idx    = addr[7:2];
        e.adr  = {addr[31:2], 2'b00};
        e.we   = 1'b0;
        e.sel  = lane_mask(r.op, lane);
        e.dat  = '0;
        e.word = shadow[idx];
        w.rt   = r.rt;
        w.data = '0;
        case (r.op)
            lsu_pkg::OP_LUI: begin
                w.data = {r.offset, 16'h0000};
                wb_q.push_back(w);
            end
            lsu_pkg::OP_SB, lsu_pkg::OP_SH, lsu_pkg::OP_SW: begin
                e.we        = 1'b1;
                e.dat       = store_data(r.op, lane, r.rt_data);
                e.word      = merge_store(shadow[idx], e.sel, e.dat);
                shadow[idx] = e.word;
                bus_q.push_back(e);
            end
            default: begin
                w.data = load_value(r.op, lane, shadow[idx], r.rt_data);
                bus_q.push_back(e);
                wb_q.push_back(w);
            end
        endcase
    endtask

    task automatic check_bus();
        bus_exp_t    e;
        logic [31:0] lanes;
        if (bus_q.size() == 0) begin
            report_failure("bus cycle without a pending request");
        end else begin
            e = bus_q.pop_front();
            for (int k = 0; k < 4; k++) begin
                lanes[31-8*k -: 8] = {8{e.sel[3-k]}};
            end
            assert (wbm_o.cyc && wbm_o.stb)
                else report_failure("ack arrived while cyc or stb was low");
            assert (wbm_o.adr == e.adr)
                else report_failure($sformatf("bus adr %h, expected %h", wbm_o.adr, e.adr));
            assert (wbm_o.we == e.we)
                else report_failure($sformatf("bus we %b, expected %b", wbm_o.we, e.we));
            assert (wbm_o.sel == e.sel)
                else report_failure($sformatf("bus sel %b, expected %b", wbm_o.sel, e.sel));
            if (e.we) begin
                assert ((wbm_o.dat & lanes) == e.dat)
                    else report_failure($sformatf("bus dat %h in lanes, expected %h",
                                                  wbm_o.dat & lanes, e.dat));
                assert (i_mem.mem[e.adr[7:2]] == e.word)
                    else report_failure($sformatf("memory word %h, shadow %h",
                                                  i_mem.mem[e.adr[7:2]], e.word));
            end
        end
    endtask

    task automatic check_writeback();
        lsu_pkg::lsu_wb_t w;
        if (wb_q.size() == 0) begin
            report_failure("writeback without a pending load");
        end else begin
            w = wb_q.pop_front();
            assert (wb.rt == w.rt)
                else report_failure($sformatf("wb rt %0d, expected %0d", wb.rt, w.rt));
            assert (wb.data == w.data)
                else report_failure($sformatf("wb data %h, expected %h", wb.data, w.data));
        end
    endtask

    task automatic send_request(input lsu_pkg::lsu_op_e op, input logic [1:0] lane);
        logic [31:0] base;
        logic [31:0] rt_data;
        logic [15:0] offset;
        logic [4:0]  rt;
        req_rng = lcg_step(req_rng);
        base    = {req_rng[31:2], 2'b00};
        req_rng = lcg_step(req_rng);
        rt_data = req_rng;
        req_rng = lcg_step(req_rng);
        offset  = {req_rng[15:2], lane};  // Sign bit random, so negative too
        rt      = req_rng[20:16];
        if (req_rng[31:29] == 3'b000) begin
            @(negedge clk);
            req_valid = 1'b0;  // Occasional idle cycle
        end
        @(negedge clk);
        req_valid   = 1'b1;
        req.op      = op;
        req.base    = base;
        req.offset  = offset;
        req.rt_data = rt_data;
        req.rt      = rt;
        @(posedge clk);
        while (!req_fire) begin
            @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        if (arst_n) begin
            if (req_fire) begin
                record_request(req);
            end
            if (wbm_i.ack) begin
                check_bus();
            end
            if (wb_valid && wb_ready) begin
                check_writeback();
            end
        end
    end

    a_wb_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb)
    ) else report_failure("writeback changed or dropped while stalled");

    always @(negedge clk) begin
        ready_rng = lcg_step(ready_rng);
        wb_ready  = (ready_rng[31:30] != 2'b00);  // Stalls about a quarter of cycles
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        for (int w = 0; w < 64; w++) begin
            shadow[w] = initial_word(w);
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        assert (req_ready && !wb_valid && !wbm_o.cyc && !wbm_o.stb && !wbm_o.we)
            else report_failure("outputs not in their reset state after reset");

        // Every op at every lane, then a random mix
        for (int n = 0; n < 11; n++) begin
            for (int l = 0; l < 4; l++) begin
                send_request(pick_op(n), 2'(l));
            end
        end
        for (int i = 0; i < NUM_REQ - 44; i++) begin
            req_rng = lcg_step(req_rng);
            send_request(pick_op(int'(req_rng[31:16] % 16'd11)), req_rng[9:8]);
        end
        @(negedge clk);
        req_valid = 1'b0;

        while (bus_q.size() != 0 || wb_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);  // Quiet period for stray writebacks
        if (!wb_valid && !wbm_o.cyc && !wbm_o.stb) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            report_failure("unit still busy after all writebacks");
        end
    end

endmodule

// File: tests/tb_wb_memory.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module tb_wb_memory #(
    parameter logic [31:0] SEED = 32'h7f69_1157
) (
    input  logic                clk,
    input  logic                arst_n,
    input  lsu_pkg::lsu_wbm_o_t wbm_o,
    output lsu_pkg::lsu_wbm_i_t wbm_i
);

    localparam int WORDS = 64;

    logic [`LSU_XLEN-1:0] mem [0:WORDS-1];
    logic [31:0]          rng;
    logic [1:0]           wait_cnt;
    logic [5:0]           idx;

    assign idx = wbm_o.adr[7:2];  // Upper address bits alias

    function automatic logic [31:0] next_state(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Every byte depends on its full byte address
    function automatic logic [31:0] fill_word(input int w);
        logic [7:0]  b;
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < 4; k++) begin
            b = 8'(w * 4 + k);
            v[31-8*k -: 8] = (b * 8'h3b) ^ 8'h96;
        end
        return v;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rng      <= SEED;
            wait_cnt <= 2'd0;
            wbm_i    <= '0;
            for (int w = 0; w < WORDS; w++) begin
                mem[w] <= fill_word(w);
            end
        end else begin
            wbm_i.ack <= 1'b0;
            if (wbm_o.cyc && wbm_o.stb && !wbm_i.ack) begin
                if (wait_cnt == 2'd0) begin
                    wbm_i.ack <= 1'b1;
                    wbm_i.dat <= mem[idx];
                    if (wbm_o.we) begin
                        for (int k = 0; k < 4; k++) begin
                            if (wbm_o.sel[3-k]) begin
                                mem[idx][31-8*k -: 8] <= wbm_o.dat[31-8*k -: 8];  // Lane k
                            end
                        end
                    end
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end else begin
                rng      <= next_state(rng);
                wait_cnt <= rng[17:16];  // Wait states for the next cycle
            end
        end
    end

endmodule
